// ==== Bender.yml ====
package:
  name: i3c_ddr_tx

sources:
  - include_dirs:
      - source
    files:
      - source/i3c_ddr_pkg.sv
      - source/ddr_frame_sequencer.sv
      - source/ddr_bit_serializer.sv
      - source/ddr_crc5.sv
      - source/scl_edge_gen.sv
      - source/i3c_ddr_tx_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - sim/tb_i3c_ddr_tx.sv

// ==== sim.f ====
+incdir+source
source/i3c_ddr_pkg.sv
source/ddr_frame_sequencer.sv
source/ddr_bit_serializer.sv
source/ddr_crc5.sv
source/scl_edge_gen.sv
source/i3c_ddr_tx_top.sv
sim/tb_i3c_ddr_tx.sv

// ==== sim/ddr_tx_trace.txt ====
# rnw addr two_words d0 d1 d2 d3 end_restart nbits sda_bits crc5
# hex fields except nbits (decimal) and sda_bits (first bit on the left)
0 50 0 12 34 5A C3 1 57 010000000010100000011000010010001101000001110001011101011 0B
1 2A 1 A5 0F 00 FF 0 80 01100000000101010011101010010100001111011000000000111111110101110000101101010101 05
0 01 0 00 00 5A C3 0 60 010000000000000011111000000000000000000101110010110101010101 16

// ==== sim/tb_i3c_ddr_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "i3c_ddr_defs.svh"

module tb_i3c_ddr_tx;

	localparam int MAX_FRAMES = 16;
	localparam int MAX_BITS   = 80; // two data words and exit

	logic                    i_sys_clk;
	logic                    i_sys_rst;
	logic                    i_frame_start;
	i3c_ddr_pkg::ddr_frame_t i_frame;
	logic                    o_scl;
	logic                    o_sda;
	logic                    o_busy;
	logic                    o_frame_done;

	i3c_ddr_pkg::ddr_frame_t tr_frame [MAX_FRAMES];
	int                      tr_nbits [MAX_FRAMES];
	logic [127:0]            tr_bits  [MAX_FRAMES];
	i3c_ddr_pkg::ddr_crc_t   tr_crc   [MAX_FRAMES];
	int                      n_frames;

	bit     sda_q[$];       // SDA seen at each SCL transition
	logic   scl_prev;
	int     done_cnt;
	int     cycle_cnt;
	int     cycle_limit;
	int     err_bits;
	int     err_crc;
	int     err_flag;
	integer seed;

	i3c_ddr_tx_top u_dut (
		.i_sys_clk     (i_sys_clk),
		.i_sys_rst     (i_sys_rst),
		.i_frame_start (i_frame_start),
		.i_frame       (i_frame),
		.o_scl         (o_scl),
		.o_sda         (o_sda),
		.o_busy        (o_busy),
		.o_frame_done  (o_frame_done)
	);

	initial
	begin
		i_sys_clk = 1'b0;
		forever #4 i_sys_clk = ~i_sys_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// bus monitor and run limit
	////////////////////////////////////////////////////////////////////////////
	always @(posedge i_sys_clk)
	begin
		scl_prev <= o_scl;
		if (o_busy && (o_scl !== scl_prev))
			sda_q.push_back(o_sda);
		if (o_frame_done)
			done_cnt <= done_cnt + 1;
	end

	always @(posedge i_sys_clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit)
		begin
			$display("timeout after %0d cycles, a frame never finished", cycle_cnt);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic string bits_to_str(input logic [127:0] v, input int n);
		string s;
		s = "";
		for (int i = n - 1; i >= 0; i--)
			s = {s, v[i] ? "1" : "0"};
		return s;
	endfunction

	task automatic check_bits(input string name, input logic [127:0] exp_v, input int exp_n,
		input logic [127:0] act_v, input int act_n);
		if ((exp_n != act_n) || (exp_v !== act_v))
		begin
			err_bits++;
			$display("ERR %s: expected %0d bits %s, actual %0d bits %s", name, exp_n,
				bits_to_str(exp_v, exp_n), act_n, bits_to_str(act_v, act_n));
		end
	endtask

	task automatic check_crc(input string name, input i3c_ddr_pkg::ddr_crc_t exp_c,
		input i3c_ddr_pkg::ddr_crc_t act_c);
		if (exp_c !== act_c)
		begin
			err_crc++;
			$display("ERR %s: expected crc %b, actual %b", name, exp_c, act_c);
		end
	endtask

	task automatic check_flag(input string name, input logic exp_f, input logic act_f);
		if (exp_f !== act_f)
		begin
			err_flag++;
			$display("ERR %s: expected %b, actual %b", name, exp_f, act_f);
		end
	endtask

	task automatic read_trace();
		int           fd;
		int           rc;
		string        line;
		logic [31:0]  f_rnw;
		logic [31:0]  f_addr;
		logic [31:0]  f_two;
		logic [31:0]  d0;
		logic [31:0]  d1;
		logic [31:0]  d2;
		logic [31:0]  d3;
		logic [31:0]  f_end;
		int           nb;
		logic [127:0] bits;
		logic [31:0]  crc;
		fd = $fopen("sim/ddr_tx_trace.txt", "r");
		if (fd == 0)
		begin
			$display("could not open sim/ddr_tx_trace.txt");
			err_flag++;
			return;
		end
		while (!$feof(fd) && (n_frames < MAX_FRAMES))
		begin
			rc = $fgets(line, fd);
			if (rc == 0)
				break;
			if ((line.len() < 2) || (line[0] == "#"))
				continue; // comment or blank
			bits = '0;
			rc = $sscanf(line, "%h %h %h %h %h %h %h %h %d %b %h", f_rnw, f_addr, f_two,
				d0, d1, d2, d3, f_end, nb, bits, crc);
			if (rc != 11)
			begin
				$display("malformed trace line: %s", line);
				err_flag++;
				continue;
			end
			tr_frame[n_frames].rnw         = f_rnw[0];
			tr_frame[n_frames].addr        = f_addr[6:0];
			tr_frame[n_frames].two_words   = f_two[0];
			tr_frame[n_frames].data[0]     = d0[7:0];
			tr_frame[n_frames].data[1]     = d1[7:0];
			tr_frame[n_frames].data[2]     = d2[7:0];
			tr_frame[n_frames].data[3]     = d3[7:0];
			tr_frame[n_frames].end_restart = f_end[0];
			tr_nbits[n_frames]             = nb;
			tr_bits[n_frames]              = bits;
			tr_crc[n_frames]               = crc[4:0];
			n_frames++;
		end
		$fclose(fd);
	endtask

	// start strobe for one cycle, frame fields alongside
	task automatic send_frame(input i3c_ddr_pkg::ddr_frame_t f);
		@(posedge i_sys_clk);
		i_frame       <= f;
		i_frame_start <= 1'b1;
		@(posedge i_sys_clk);
		i_frame_start <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		int           gap;
		int           wait_cycles;
		int           end_len;
		int           act_n;
		logic [127:0] act_v;
		string        name;
		i_sys_rst     = 1'b0;
		i_frame_start = 1'b0;
		i_frame       = '0;
		scl_prev      = 1'b1;
		done_cnt      = 0;
		cycle_cnt     = 0;
		cycle_limit   = 100000;
		err_bits      = 0;
		err_crc       = 0;
		err_flag      = 0;
		n_frames      = 0;
		seed          = 32'h4104;
		read_trace();
		cycle_limit = n_frames * MAX_BITS * 2 * `DDR_SCL_HALF + 2000;
		if (n_frames == 0)
		begin
			$display("trace holds no frames");
			err_flag++;
		end

		repeat (10) @(posedge i_sys_clk);
		i_sys_rst <= 1'b1;
		@(posedge i_sys_clk);
		check_flag("reset busy", 1'b0, o_busy);
		check_flag("reset scl", 1'b1, o_scl);
		check_flag("reset sda", 1'b1, o_sda);
		check_flag("reset done", 1'b0, o_frame_done);

		for (int k = 0; k < n_frames; k++)
		begin
			name = $sformatf("frame %0d", k);
			gap  = $unsigned($random(seed)) % 16;
			repeat (gap) @(posedge i_sys_clk);
			sda_q.delete();
			send_frame(tr_frame[k]);
			@(posedge i_sys_clk);
			check_flag({name, " busy after start"}, 1'b1, o_busy);
			wait_cycles = 0;
			while (!o_frame_done)
			begin
				@(posedge i_sys_clk);
				wait_cycles++;
				if ((k == 1) && (wait_cycles == 40))
				begin
					i_frame       <= tr_frame[0]; // must be dropped
					i_frame_start <= 1'b1;
				end
				else
					i_frame_start <= 1'b0;
			end
			check_flag({name, " busy after done"}, 1'b0, o_busy);
			act_v = '0;
			act_n = 0;
			if (sda_q.size() > 0)
				check_flag({name, " idle sda before first bit"}, 1'b1, sda_q[0]);
			for (int i = 1; i < sda_q.size(); i++)
			begin
				act_v = {act_v[126:0], sda_q[i]};
				act_n++;
			end
			check_bits(name, tr_bits[k], tr_nbits[k], act_v, act_n);
			end_len = tr_frame[k].end_restart ? 6 : 1 + `DDR_EXIT_TOGGLES;
			check_crc(name, tr_crc[k], i3c_ddr_pkg::ddr_crc_t'(act_v >> end_len));
		end

		repeat (20) @(posedge i_sys_clk);
		check_flag("one done pulse per frame", 1'b1, done_cnt == n_frames);
		check_flag("idle busy", 1'b0, o_busy);
		check_flag("idle scl", 1'b1, o_scl);
		check_flag("idle sda", 1'b1, o_sda);

		$display("errors: bits %0d, crc %0d, flag %0d, frames %0d, done pulses %0d",
			err_bits, err_crc, err_flag, n_frames, done_cnt);
		if ((err_bits + err_crc + err_flag) == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/ddr_bit_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "i3c_ddr_defs.svh"

module ddr_bit_serializer (
	input  wire                               i_sys_clk,
	input  wire                               i_sys_rst,
	input  wire                               i_tx_en,
	input  wire  i3c_ddr_pkg::ddr_tx_mode_t   i_tx_mode,
	input  wire  i3c_ddr_pkg::ddr_byte_t      i_byte,
	input  wire                               i_rnw,
	input  wire                               i_scl_pos,
	input  wire                               i_scl_neg,
	input  wire  i3c_ddr_pkg::ddr_crc_t       i_crc,
	output logic                              o_sda,
	output logic                              o_mode_done,
	output i3c_ddr_pkg::ddr_crc_feed_t        o_crc_feed
);

	i3c_ddr_pkg::ddr_bitcnt_t bit_cnt;
	i3c_ddr_pkg::ddr_bitcnt_t last_bit;  // index of the final bit of the mode
	i3c_ddr_pkg::ddr_byte_t   word_hi;
	i3c_ddr_pkg::ddr_byte_t   word_lo;
	i3c_ddr_pkg::ddr_byte_t   cur_byte;
	logic [15:0]              mode_bits; // left aligned, MSB goes first
	logic                     scl_edge;
	logic                     byte_mode;
	logic                     parity_adj;
	logic                     p1;
	logic                     p0;
	logic                     cmd_word;  // current word is the command word
	logic                     lo_next;   // next byte is the second of the word

	assign scl_edge   = i_scl_pos | i_scl_neg;
	assign parity_adj = i_rnw ^ (^i_byte[7:1]);
	assign cur_byte   = (i_tx_mode == i3c_ddr_pkg::ADDRESS) ? {i_byte[7:1], parity_adj} : i_byte;
	assign byte_mode  = (i_tx_mode == i3c_ddr_pkg::CMD_HIGH) ||
		(i_tx_mode == i3c_ddr_pkg::ADDRESS) ||
		(i_tx_mode == i3c_ddr_pkg::DATA_BYTE);

	////////////////////////////////////////////////////////////////////////////
	// word parity
	////////////////////////////////////////////////////////////////////////////
	assign p1 = ^{word_hi & 8'hAA, word_lo & 8'hAA};                 // odd positions
	assign p0 = cmd_word ? 1'b1 : ~(^{word_hi & 8'h55, word_lo & 8'h55});

	// bit pattern and length of each mode
	always_comb
	begin
		mode_bits = '0;
		last_bit  = '0;
		case (i_tx_mode)
			i3c_ddr_pkg::PREAMBLE_CMD:
			begin
				mode_bits = {`DDR_PRE_CMD, 14'b0};
				last_bit  = 4'd1;
			end
			i3c_ddr_pkg::PREAMBLE_DATA:
			begin
				mode_bits = {`DDR_PRE_DATA, 14'b0};
				last_bit  = 4'd1;
			end
			i3c_ddr_pkg::CMD_HIGH, i3c_ddr_pkg::ADDRESS, i3c_ddr_pkg::DATA_BYTE:
			begin
				mode_bits = {cur_byte, 8'b0};
				last_bit  = 4'd7;
			end
			i3c_ddr_pkg::PARITY:
			begin
				mode_bits = {p1, p0, 14'b0};
				last_bit  = 4'd1;
			end
			i3c_ddr_pkg::CRC_TOKEN:
			begin
				mode_bits = {`DDR_CRC_TOKEN, 12'b0};
				last_bit  = 4'd3;
			end
			i3c_ddr_pkg::CRC_VALUE:
			begin
				mode_bits = {i_crc, 11'b0};
				last_bit  = 4'd4;
			end
			i3c_ddr_pkg::RESTART:
			begin
				mode_bits = {1'b1, `DDR_RESTART_PAT, 10'b0};
				last_bit  = 4'd5;
			end
			i3c_ddr_pkg::EXIT:
			begin
				mode_bits = 16'hAAAA; // leading 1 then toggles
				last_bit  = i3c_ddr_pkg::ddr_bitcnt_t'(`DDR_EXIT_TOGGLES);
			end
			default:
			begin
				mode_bits = 16'hFFFF;
				last_bit  = '0;
			end
		endcase
	end

	// bytes of the current word, kept for the parity bits
	always_ff @(posedge i_sys_clk)
	begin
		if (i_tx_en && scl_edge && (bit_cnt == '0) && byte_mode)
		begin
			if (lo_next)
				word_lo <= cur_byte;
			else
				word_hi <= cur_byte;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// shift out one bit per SCL edge
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			bit_cnt     <= '0;
			o_sda       <= 1'b1;
			o_mode_done <= 1'b0;
			cmd_word    <= 1'b1;
			lo_next     <= 1'b0;
			o_crc_feed  <= '0;
		end
		else
		begin
			o_mode_done      <= 1'b0;
			o_crc_feed.valid <= 1'b0;
			o_crc_feed.first <= 1'b0;
			o_crc_feed.last  <= 1'b0;
			if (!i_tx_en)
			begin
				bit_cnt <= '0;
				o_sda   <= 1'b1; // bus idles high
				lo_next <= 1'b0;
			end
			else if (scl_edge)
			begin
				o_sda <= mode_bits[~bit_cnt];
				if (bit_cnt == last_bit)
				begin
					bit_cnt     <= '0;
					o_mode_done <= 1'b1;
				end
				else
					bit_cnt <= bit_cnt + 1'b1;

				if (bit_cnt == '0)
				begin
					case (i_tx_mode)
						i3c_ddr_pkg::PREAMBLE_CMD:
						begin
							cmd_word <= 1'b1;
							lo_next  <= 1'b0;
						end
						i3c_ddr_pkg::PREAMBLE_DATA:
						begin
							cmd_word <= 1'b0;
							lo_next  <= 1'b0;
						end
						i3c_ddr_pkg::CMD_HIGH, i3c_ddr_pkg::ADDRESS, i3c_ddr_pkg::DATA_BYTE:
						begin
							o_crc_feed.value <= cur_byte;
							o_crc_feed.valid <= 1'b1;
							o_crc_feed.first <= (i_tx_mode == i3c_ddr_pkg::CMD_HIGH);
							lo_next          <= ~lo_next;
						end
						i3c_ddr_pkg::CRC_TOKEN:
							o_crc_feed.last <= 1'b1; // freeze the CRC
						default:
						begin
						end
					endcase
				end
			end
		end
	end

	// edges are DDR_SCL_HALF apart, so a mode cannot end twice back to back
	a_mode_done_single: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		o_mode_done |=> !o_mode_done);

endmodule

`default_nettype wire

// ==== source/ddr_crc5.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "i3c_ddr_defs.svh"

module ddr_crc5 (
	input  wire                                i_sys_clk,
	input  wire                                i_sys_rst,
	input  wire  i3c_ddr_pkg::ddr_crc_feed_t   i_feed,
	output i3c_ddr_pkg::ddr_crc_t              o_crc
);

	i3c_ddr_pkg::ddr_crc_t crc_base;
	logic                  frozen; // result held after last

	// one byte through x^5+x^2+1, MSB first
	function automatic i3c_ddr_pkg::ddr_crc_t crc5_byte(
		input i3c_ddr_pkg::ddr_crc_t  crc_in,
		input i3c_ddr_pkg::ddr_byte_t data
	);
		i3c_ddr_pkg::ddr_crc_t c;
		logic                  fb;
		c = crc_in;
		for (int i = 7; i >= 0; i--)
		begin
			fb = c[4] ^ data[i];
			c  = {c[3:0], 1'b0} ^ {2'b00, fb, 1'b0, fb};
		end
		return c;
	endfunction

	assign crc_base = i_feed.first ? i3c_ddr_pkg::ddr_crc_t'(`DDR_CRC_INIT) : o_crc;

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			o_crc  <= `DDR_CRC_INIT;
			frozen <= 1'b0;
		end
		else
		begin
			if (i_feed.valid && (i_feed.first || !frozen))
				o_crc <= crc5_byte(crc_base, i_feed.value);
			if (i_feed.first)
				frozen <= 1'b0;
			else if (i_feed.last)
				frozen <= 1'b1;
		end
	end

	a_feed_after_last: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(i_feed.valid && frozen) |-> i_feed.first);

endmodule

`default_nettype wire

// ==== source/ddr_frame_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "i3c_ddr_defs.svh"

module ddr_frame_sequencer (
	input  wire                              i_sys_clk,
	input  wire                              i_sys_rst,
	input  wire                              i_frame_start,
	input  wire  i3c_ddr_pkg::ddr_frame_t    i_frame,
	input  wire                              i_mode_done,
	output logic                             o_tx_en,
	output i3c_ddr_pkg::ddr_tx_mode_t        o_tx_mode,
	output i3c_ddr_pkg::ddr_byte_t           o_byte,
	output logic                             o_rnw,
	output logic                             o_busy,
	output logic                             o_frame_done
);

	localparam int unsigned TAIL_W = $clog2(`DDR_SCL_HALF);

	i3c_ddr_pkg::ddr_seq_state_t state;
	i3c_ddr_pkg::ddr_frame_t     frame_q;
	logic [3:0]                  step;     // position in the mode list
	logic [TAIL_W-1:0]           tail_cnt;
	logic                        accept;

	assign accept  = i_frame_start & ~o_busy;
	assign o_tx_en = (state != i3c_ddr_pkg::IDLE);
	assign o_rnw   = frame_q.rnw;

	always_ff @(posedge i_sys_clk)
	begin
		if (accept)
		begin
			frame_q <= i_frame;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// frame control
	// CLOSE keeps SCL running until the last bit has been clocked out
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			state        <= i3c_ddr_pkg::IDLE;
			step         <= '0;
			tail_cnt     <= '0;
			o_busy       <= 1'b0;
			o_frame_done <= 1'b0;
		end
		else
		begin
			o_frame_done <= 1'b0;
			case (state)
				i3c_ddr_pkg::IDLE:
				begin
					if (accept)
					begin
						state  <= i3c_ddr_pkg::RUN;
						step   <= '0;
						o_busy <= 1'b1;
					end
					else if (o_busy)
					begin
						o_busy       <= 1'b0; // one cycle after SCL stops
						o_frame_done <= 1'b1;
					end
				end
				i3c_ddr_pkg::RUN:
				begin
					if (i_mode_done)
					begin
						if (step == 4'd15)
						begin
							state    <= i3c_ddr_pkg::CLOSE;
							tail_cnt <= TAIL_W'(`DDR_SCL_HALF - 3);
						end
						else if ((step == 4'd7) && !frame_q.two_words)
							step <= 4'd12; // skip second data word
						else
							step <= step + 4'd1;
					end
				end
				i3c_ddr_pkg::CLOSE:
				begin
					if (tail_cnt == '0)
						state <= i3c_ddr_pkg::IDLE;
					else
						tail_cnt <= tail_cnt - 1'b1;
				end
				default:
					state <= i3c_ddr_pkg::IDLE;
			endcase
		end
	end

	// mode and byte for each step
	always_comb
	begin
		o_byte = '0;
		case (step)
			4'd0, 4'd12:        o_tx_mode = i3c_ddr_pkg::PREAMBLE_CMD;
			4'd1:
			begin
				o_tx_mode = i3c_ddr_pkg::CMD_HIGH;
				o_byte    = {frame_q.rnw, 7'b0000000};
			end
			4'd2:
			begin
				o_tx_mode = i3c_ddr_pkg::ADDRESS;
				o_byte    = {frame_q.addr, 1'b0}; // low bit replaced downstream
			end
			4'd3, 4'd7, 4'd11:  o_tx_mode = i3c_ddr_pkg::PARITY;
			4'd4, 4'd8:         o_tx_mode = i3c_ddr_pkg::PREAMBLE_DATA;
			4'd5, 4'd6, 4'd9, 4'd10:
			begin
				o_tx_mode = i3c_ddr_pkg::DATA_BYTE;
				o_byte    = frame_q.data[{step[3], ~step[0]}]; // steps 5,6,9,10
			end
			4'd13:              o_tx_mode = i3c_ddr_pkg::CRC_TOKEN;
			4'd14:              o_tx_mode = i3c_ddr_pkg::CRC_VALUE;
			default:
				o_tx_mode = frame_q.end_restart ? i3c_ddr_pkg::RESTART : i3c_ddr_pkg::EXIT;
		endcase
	end

	a_start_while_busy: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		i_frame_start |-> !o_busy)
		else $warning("frame start dropped, frame already in progress");

endmodule

`default_nettype wire

// ==== source/i3c_ddr_defs.svh ====
`ifndef I3C_DDR_DEFS_SVH
`define I3C_DDR_DEFS_SVH

// system clocks per SCL half period
// the sequencer tail needs at least 3
`define DDR_SCL_HALF      4

// word preambles, sent MSB first
`define DDR_PRE_CMD       2'b01
`define DDR_PRE_DATA      2'b10

// CRC word
`define DDR_CRC_TOKEN     4'b1100
`define DDR_CRC_INIT      5'b11111

// closing patterns, both start with a 1
`define DDR_RESTART_PAT   5'b01011
`define DDR_EXIT_TOGGLES  8

`endif

// ==== source/i3c_ddr_pkg.sv ====
`default_nettype none

package i3c_ddr_pkg;

	typedef logic [7:0] ddr_byte_t;
	typedef logic [4:0] ddr_crc_t;
	typedef logic [6:0] ddr_addr_t;   // target address or CCC code
	typedef logic [3:0] ddr_bitcnt_t; // bit index inside one mode

	typedef enum logic [3:0] {
		PREAMBLE_CMD  = 4'd0,
		PREAMBLE_DATA = 4'd1,
		CMD_HIGH      = 4'd2, // {rnw, seven zeros}
		ADDRESS       = 4'd3, // address plus parity_adj
		DATA_BYTE     = 4'd4,
		PARITY        = 4'd5,
		CRC_TOKEN     = 4'd6,
		CRC_VALUE     = 4'd7,
		RESTART       = 4'd8,
		EXIT          = 4'd9
	} ddr_tx_mode_t;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		RUN   = 2'd1,
		CLOSE = 2'd2
	} ddr_seq_state_t;

	typedef struct packed {
		logic            rnw;
		ddr_addr_t       addr;
		logic            two_words;   // 0 one data word, 1 two
		ddr_byte_t [0:3] data;        // data[0] goes out first
		logic            end_restart; // 1 restart, 0 exit
	} ddr_frame_t;

	typedef struct packed {
		ddr_byte_t value;
		logic      valid;
		logic      first;
		logic      last;
	} ddr_crc_feed_t;

endpackage

`default_nettype wire

// ==== source/i3c_ddr_tx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module i3c_ddr_tx_top (
	input  wire                              i_sys_clk,
	input  wire                              i_sys_rst,
	input  wire                              i_frame_start,
	input  wire  i3c_ddr_pkg::ddr_frame_t    i_frame,
	output logic                             o_scl,
	output logic                             o_sda,
	output logic                             o_busy,
	output logic                             o_frame_done
);

	logic                          seq_tx_en;
	i3c_ddr_pkg::ddr_tx_mode_t     seq_tx_mode;
	i3c_ddr_pkg::ddr_byte_t        seq_byte;
	logic                          seq_rnw;
	logic                          ser_mode_done;
	logic                          scl_pos;
	logic                          scl_neg;
	i3c_ddr_pkg::ddr_crc_feed_t    crc_feed;
	i3c_ddr_pkg::ddr_crc_t         crc_value;

	ddr_frame_sequencer u_seq (
		.i_sys_clk     (i_sys_clk),
		.i_sys_rst     (i_sys_rst),
		.i_frame_start (i_frame_start),
		.i_frame       (i_frame),
		.i_mode_done   (ser_mode_done),
		.o_tx_en       (seq_tx_en),
		.o_tx_mode     (seq_tx_mode),
		.o_byte        (seq_byte),
		.o_rnw         (seq_rnw),
		.o_busy        (o_busy),
		.o_frame_done  (o_frame_done)
	);

	ddr_bit_serializer u_ser (
		.i_sys_clk   (i_sys_clk),
		.i_sys_rst   (i_sys_rst),
		.i_tx_en     (seq_tx_en),
		.i_tx_mode   (seq_tx_mode),
		.i_byte      (seq_byte),
		.i_rnw       (seq_rnw),
		.i_scl_pos   (scl_pos),
		.i_scl_neg   (scl_neg),
		.i_crc       (crc_value),
		.o_sda       (o_sda),
		.o_mode_done (ser_mode_done),
		.o_crc_feed  (crc_feed)
	);

	ddr_crc5 u_crc (
		.i_sys_clk (i_sys_clk),
		.i_sys_rst (i_sys_rst),
		.i_feed    (crc_feed),
		.o_crc     (crc_value)
	);

	scl_edge_gen u_scl (
		.i_sys_clk (i_sys_clk),
		.i_sys_rst (i_sys_rst),
		.i_run     (seq_tx_en),
		.o_scl     (o_scl),
		.o_scl_pos (scl_pos),
		.o_scl_neg (scl_neg)
	);

endmodule

`default_nettype wire

// ==== source/scl_edge_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "i3c_ddr_defs.svh"

module scl_edge_gen (
	input  wire  i_sys_clk,
	input  wire  i_sys_rst,
	input  wire  i_run,
	output logic o_scl,
	output logic o_scl_pos,
	output logic o_scl_neg
);

	localparam int unsigned DIV_W = $clog2(`DDR_SCL_HALF);

	logic [DIV_W-1:0] div_cnt;
	logic             half_end;

	assign half_end = (div_cnt == DIV_W'(`DDR_SCL_HALF - 1));

	// strobes come out with the SCL transition they mark
	// a low SCL left after a frame is raised one half period later
	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			div_cnt   <= '0;
			o_scl     <= 1'b1;
			o_scl_pos <= 1'b0;
			o_scl_neg <= 1'b0;
		end
		else
		begin
			o_scl_pos <= 1'b0;
			o_scl_neg <= 1'b0;
			if (i_run || !o_scl)
			begin
				if (half_end)
				begin
					div_cnt <= '0;
					o_scl   <= ~o_scl;
					if (i_run)
					begin
						o_scl_pos <= ~o_scl;
						o_scl_neg <= o_scl;
					end
				end
				else
					div_cnt <= div_cnt + 1'b1;
			end
			else
				div_cnt <= '0; // parked high
		end
	end

endmodule

`default_nettype wire
